// File: design/snowball_pkg.sv
package snowball_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  parameter int addr_w = 32;
  parameter int data_w = 32;
  parameter int idx_w  = 8;                    // Store depth is 2**idx_w

  // ------------------------------
  // Store entries
  // ------------------------------
  typedef struct packed {
    logic [23:0]       tag;                    // Physical address bits 31:8
    logic [data_w-1:0] data;
  } line_t;

  typedef struct packed {
    logic [15:0] vtag;                         // Virtual address bits 31:16
    logic [15:0] page;                         // Replaces bits 31:16
  } tlb_t;

  // ------------------------------
  // Request kinds
  // ------------------------------
  typedef enum logic [1:0] {
    op_read      = 2'd0,
    op_write     = 2'd1,
    op_tlb_write = 2'd2
  } op_e;

endpackage

// File: design/mapped_store.sv
`timescale 1ns/1ps

module mapped_store #(
  parameter int  idx_w   = snowball_pkg::idx_w,
  parameter type entry_t = logic [snowball_pkg::data_w-1:0]
) (
  input  logic             CPU_CLK,
  input  logic             RST,
  input  logic             rd_en,
  input  logic [idx_w-1:0] rd_idx,
  output entry_t           rd_entry,
  output logic             rd_valid,
  input  logic             wr_en,
  input  logic [idx_w-1:0] wr_idx,
  input  entry_t           wr_entry
);

  localparam int depth = 2 ** idx_w;

  entry_t           entries [depth];
  logic [depth-1:0] valid;

  // Entry array and registered read data
  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      entries[wr_idx] <= wr_entry;
    end
    if (rd_en)
    begin
      rd_entry <= entries[rd_idx];              // Held until next read
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      valid    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
      begin
        valid[wr_idx] <= 1'b1;
      end
      if (rd_en)
      begin
        rd_valid <= valid[rd_idx];              // Old state on same-index write
      end
    end
  end

  a_valid_known : assert property (@(posedge CPU_CLK) disable iff (RST)
    !$isunknown(rd_valid));

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int idx_w = snowball_pkg::idx_w
) (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  // CPU side
  input  logic                            cache_enable,
  input  snowball_pkg::op_e               cache_op,
  input  logic [snowball_pkg::addr_w-1:0] cache_addr,
  input  logic [snowball_pkg::data_w-1:0] cache_wdata,
  input  logic                            cache_force_miss,
  input  logic                            cache_inhibit,
  input  logic                            vmem_act,
  output logic                            cache_busy,
  output logic [snowball_pkg::data_w-1:0] cache_rdata,
  output logic                            cache_done,
  output logic                            mmu_fault,
  // Line store
  output logic                            line_rd_en,
  output logic [idx_w-1:0]                line_rd_idx,
  output logic                            line_wr_en,
  output logic [idx_w-1:0]                line_wr_idx,
  output snowball_pkg::line_t             line_wr_entry,
  input  snowball_pkg::line_t             line_rd_entry,
  input  logic                            line_rd_valid,
  // TLB store
  output logic                            tlb_rd_en,
  output logic [idx_w-1:0]                tlb_rd_idx,
  output logic                            tlb_wr_en,
  output logic [idx_w-1:0]                tlb_wr_idx,
  output snowball_pkg::tlb_t              tlb_wr_entry,
  input  snowball_pkg::tlb_t              tlb_rd_entry,
  input  logic                            tlb_rd_valid,
  // Memory port
  output logic                            port_start,
  output logic                            port_we,
  output logic [snowball_pkg::addr_w-1:0] port_addr,
  output logic [snowball_pkg::data_w-1:0] port_wdata,
  input  logic                            port_done,
  input  logic [snowball_pkg::data_w-1:0] port_rdata
);

  typedef enum logic [2:0] {s_idle, s_look, s_cmp, s_mem, s_tlb} state_t;

  state_t                          state;
  snowball_pkg::op_e               req_op;
  logic [snowball_pkg::addr_w-1:0] req_addr;
  logic [snowball_pkg::data_w-1:0] req_wdata;
  logic                            req_force_miss;
  logic                            req_inhibit;
  logic                            req_vmem;
  logic [snowball_pkg::addr_w-1:0] paddr_q;      // Translated address
  logic                            fault_q;
  logic                            port_wait;
  logic                            accept;
  logic                            is_read;
  logic                            line_hit;
  logic [snowball_pkg::addr_w-1:0] look_paddr;
  logic                            look_fault;

  assign accept  = cache_enable && !cache_busy;
  assign is_read = (req_op != snowball_pkg::op_write);

  // Both stores read on the acceptance edge
  assign line_rd_en  = accept;
  assign line_rd_idx = cache_addr[idx_w-1:0];
  assign tlb_rd_en   = accept;
  assign tlb_rd_idx  = cache_addr[8 +: idx_w];

  // ------------------------------
  // Translation, in s_look
  // ------------------------------
  always_comb
  begin
    look_paddr = req_addr;
    look_fault = 1'b0;
    if (req_vmem)
    begin
      look_paddr = {tlb_rd_entry.page, req_addr[15:0]};
      look_fault = !tlb_rd_valid || (tlb_rd_entry.vtag != req_addr[31:16]);
    end
  end

  // Tag compare, in s_cmp
  assign line_hit = line_rd_valid && (line_rd_entry.tag == paddr_q[31:8]) &&
                    is_read && !req_force_miss && !req_inhibit;

  assign port_start = (state == s_cmp) && !fault_q && !line_hit;
  assign port_we    = !is_read;
  assign port_addr  = paddr_q;
  assign port_wdata = req_wdata;

  // Refill on memory completion; inhibited reads leave the line alone
  assign line_wr_en          = (state == s_mem) && port_done && !(is_read && req_inhibit);
  assign line_wr_idx         = req_addr[idx_w-1:0];
  assign line_wr_entry.tag   = paddr_q[31:8];
  assign line_wr_entry.data  = is_read ? port_rdata : req_wdata;

  assign tlb_wr_en         = (state == s_tlb);
  assign tlb_wr_idx        = req_addr[8 +: idx_w];
  assign tlb_wr_entry.vtag = req_wdata[31:16];
  assign tlb_wr_entry.page = req_wdata[15:0];

  // ------------------------------
  // Request FSM
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= s_idle;
      cache_busy <= 1'b0;
      cache_done <= 1'b0;
      mmu_fault  <= 1'b0;
      fault_q    <= 1'b0;
      port_wait  <= 1'b0;
    end
    else
    begin
      cache_done <= 1'b0;                       // Single-cycle pulses
      mmu_fault  <= 1'b0;
      if (port_start)
        port_wait <= 1'b1;
      else if (port_done)
        port_wait <= 1'b0;
      case (state)
        s_idle:
        begin
          if (accept)
          begin
            cache_busy <= 1'b1;
            state      <= (cache_op == snowball_pkg::op_tlb_write) ? s_tlb : s_look;
          end
        end
        s_look:
        begin
          fault_q <= look_fault;
          state   <= s_cmp;
        end
        s_cmp:
        begin
          if (fault_q || line_hit)
          begin
            cache_done <= 1'b1;
            mmu_fault  <= fault_q;
            cache_busy <= 1'b0;
            state      <= s_idle;
          end
          else
          begin
            state <= s_mem;
          end
        end
        s_mem:
        begin
          if (port_done)
          begin
            cache_done <= 1'b1;
            cache_busy <= 1'b0;
            state      <= s_idle;
          end
        end
        default:                                // s_tlb
        begin
          cache_done <= 1'b1;
          cache_busy <= 1'b0;
          state      <= s_idle;
        end
      endcase
    end
  end

  // Request and result payload
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_op         <= cache_op;
      req_addr       <= cache_addr;
      req_wdata      <= cache_wdata;
      req_force_miss <= cache_force_miss;
      req_inhibit    <= cache_inhibit;
      req_vmem       <= vmem_act;
    end
    if (state == s_look)
      paddr_q <= look_paddr;
    if ((state == s_cmp) && line_hit)
      cache_rdata <= line_rd_entry.data;
    else if ((state == s_mem) && port_done && is_read)
      cache_rdata <= port_rdata;
  end

  a_start_idle : assert property (@(posedge CPU_CLK) disable iff (RST)
    port_start |-> !port_wait);

  a_done_accept : assert property (@(posedge CPU_CLK) disable iff (RST)
    accept |=> !cache_done);

endmodule

// File: design/mem_port.sv
`timescale 1ns/1ps

module mem_port (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  // Controller side
  input  logic                            port_start,
  input  logic                            port_we,
  input  logic [snowball_pkg::addr_w-1:0] port_addr,
  input  logic [snowball_pkg::data_w-1:0] port_wdata,
  output logic                            port_done,
  output logic [snowball_pkg::data_w-1:0] port_rdata,
  // Memory side
  output logic                            mem_req,
  output logic                            mem_we,
  output logic [snowball_pkg::addr_w-1:0] mem_addr,
  output logic [snowball_pkg::data_w-1:0] mem_wdata,
  input  logic                            mem_ack,
  input  logic [snowball_pkg::data_w-1:0] mem_rdata
);

  // ------------------------------
  // Handshake
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      mem_req   <= 1'b0;
      port_done <= 1'b0;
    end
    else
    begin
      port_done <= 1'b0;
      if (mem_req)
      begin
        if (mem_ack)
        begin
          mem_req   <= 1'b0;                    // Drop on the acknowledge edge
          port_done <= 1'b1;
        end
      end
      else if (port_start)
      begin
        mem_req <= 1'b1;
      end
    end
  end

  // Request payload and read capture
  always_ff @(posedge CPU_CLK)
  begin
    if (port_start && !mem_req)
    begin
      mem_we    <= port_we;
      mem_addr  <= port_addr;
      mem_wdata <= port_wdata;
    end
    if (mem_req && mem_ack)
    begin
      port_rdata <= mem_rdata;
    end
  end

  a_req_hold : assert property (@(posedge CPU_CLK) disable iff (RST)
    (mem_req && !mem_ack) |=>
      (mem_req && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)));

endmodule

// File: design/snowball_cache.sv
`timescale 1ns/1ps

module snowball_cache #(
  parameter int idx_w = snowball_pkg::idx_w
) (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  // CPU side
  input  logic                            cache_enable,
  input  snowball_pkg::op_e               cache_op,
  input  logic [snowball_pkg::addr_w-1:0] cache_addr,
  input  logic [snowball_pkg::data_w-1:0] cache_wdata,
  input  logic                            cache_force_miss,
  input  logic                            cache_inhibit,
  input  logic                            vmem_act,
  output logic                            cache_busy,
  output logic [snowball_pkg::data_w-1:0] cache_rdata,
  output logic                            cache_done,
  output logic                            mmu_fault,
  // Memory side
  output logic                            mem_req,
  output logic                            mem_we,
  output logic [snowball_pkg::addr_w-1:0] mem_addr,
  output logic [snowball_pkg::data_w-1:0] mem_wdata,
  input  logic                            mem_ack,
  input  logic [snowball_pkg::data_w-1:0] mem_rdata
);

  // ------------------------------
  // Store and port wiring
  // ------------------------------
  logic                            line_rd_en;
  logic [idx_w-1:0]                line_rd_idx;
  logic                            line_wr_en;
  logic [idx_w-1:0]                line_wr_idx;
  snowball_pkg::line_t             line_wr_entry;
  snowball_pkg::line_t             line_rd_entry;
  logic                            line_rd_valid;

  logic                            tlb_rd_en;
  logic [idx_w-1:0]                tlb_rd_idx;
  logic                            tlb_wr_en;
  logic [idx_w-1:0]                tlb_wr_idx;
  snowball_pkg::tlb_t              tlb_wr_entry;
  snowball_pkg::tlb_t              tlb_rd_entry;
  logic                            tlb_rd_valid;

  logic                            port_start;
  logic                            port_we;
  logic [snowball_pkg::addr_w-1:0] port_addr;
  logic [snowball_pkg::data_w-1:0] port_wdata;
  logic                            port_done;
  logic [snowball_pkg::data_w-1:0] port_rdata;

  mapped_store #(
    .idx_w   (idx_w),
    .entry_t (snowball_pkg::line_t)
  ) u_line_store (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .rd_en    (line_rd_en),
    .rd_idx   (line_rd_idx),
    .rd_entry (line_rd_entry),
    .rd_valid (line_rd_valid),
    .wr_en    (line_wr_en),
    .wr_idx   (line_wr_idx),
    .wr_entry (line_wr_entry)
  );

  mapped_store #(
    .idx_w   (idx_w),
    .entry_t (snowball_pkg::tlb_t)
  ) u_tlb_store (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .rd_en    (tlb_rd_en),
    .rd_idx   (tlb_rd_idx),
    .rd_entry (tlb_rd_entry),
    .rd_valid (tlb_rd_valid),
    .wr_en    (tlb_wr_en),
    .wr_idx   (tlb_wr_idx),
    .wr_entry (tlb_wr_entry)
  );

  cache_ctrl #(
    .idx_w (idx_w)
  ) u_cache_ctrl (
    .CPU_CLK          (CPU_CLK),
    .RST              (RST),
    .cache_enable     (cache_enable),
    .cache_op         (cache_op),
    .cache_addr       (cache_addr),
    .cache_wdata      (cache_wdata),
    .cache_force_miss (cache_force_miss),
    .cache_inhibit    (cache_inhibit),
    .vmem_act         (vmem_act),
    .cache_busy       (cache_busy),
    .cache_rdata      (cache_rdata),
    .cache_done       (cache_done),
    .mmu_fault        (mmu_fault),
    .line_rd_en       (line_rd_en),
    .line_rd_idx      (line_rd_idx),
    .line_wr_en       (line_wr_en),
    .line_wr_idx      (line_wr_idx),
    .line_wr_entry    (line_wr_entry),
    .line_rd_entry    (line_rd_entry),
    .line_rd_valid    (line_rd_valid),
    .tlb_rd_en        (tlb_rd_en),
    .tlb_rd_idx       (tlb_rd_idx),
    .tlb_wr_en        (tlb_wr_en),
    .tlb_wr_idx       (tlb_wr_idx),
    .tlb_wr_entry     (tlb_wr_entry),
    .tlb_rd_entry     (tlb_rd_entry),
    .tlb_rd_valid     (tlb_rd_valid),
    .port_start       (port_start),
    .port_we          (port_we),
    .port_addr        (port_addr),
    .port_wdata       (port_wdata),
    .port_done        (port_done),
    .port_rdata       (port_rdata)
  );

  mem_port u_mem_port (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .port_start (port_start),
    .port_we    (port_we),
    .port_addr  (port_addr),
    .port_wdata (port_wdata),
    .port_done  (port_done),
    .port_rdata (port_rdata),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

endmodule

// File: tb/tb_snowball_cache.sv
`timescale 1ns/1ps

module tb_snowball_cache;

  localparam logic [31:0] fill_key        = 32'h5a5a_c3c3;  // Memory preload pattern
  localparam int          cycles_per_line = 40;
  localparam int          reset_cycles    = 5;
  localparam string       data_path       = "tb/snowball_testdata.txt";

  logic              CPU_CLK = 1'b0;
  logic              RST;
  logic              cache_enable;
  snowball_pkg::op_e cache_op;
  logic [31:0]       cache_addr;
  logic [31:0]       cache_wdata;
  logic              cache_force_miss;
  logic              cache_inhibit;
  logic              vmem_act;
  logic              cache_busy;
  logic [31:0]       cache_rdata;
  logic              cache_done;
  logic              mmu_fault;
  logic              mem_req;
  logic              mem_we;
  logic [31:0]       mem_addr;
  logic [31:0]       mem_wdata;
  logic              mem_ack;
  logic [31:0]       mem_rdata;

  // Memory model state
  logic [31:0] mem_image [logic [31:0]];
  logic [31:0] rng_state    = 32'd81264;
  int          mem_accesses = 0;
  int          ack_delay;
  logic [31:0] rnd;
  logic [31:0] last_addr;
  logic        last_we;
  logic [31:0] last_wdata;

  // Current data-file line
  string       f_name;
  logic [1:0]  f_op;
  logic        f_force_miss;
  logic        f_inhibit;
  logic        f_vmem;
  logic [31:0] f_addr;
  logic [31:0] f_wdata;
  logic [31:0] f_exp_data;
  logic        f_exp_fault;
  int          f_exp_acc;
  logic [15:0] tlb_page [256];                   // Pages loaded so far, by TLB index
  int          watchdog_cycles = 0;

  snowball_cache u_snowball_cache (
    .CPU_CLK          (CPU_CLK),
    .RST              (RST),
    .cache_enable     (cache_enable),
    .cache_op         (cache_op),
    .cache_addr       (cache_addr),
    .cache_wdata      (cache_wdata),
    .cache_force_miss (cache_force_miss),
    .cache_inhibit    (cache_inhibit),
    .vmem_act         (vmem_act),
    .cache_busy       (cache_busy),
    .cache_rdata      (cache_rdata),
    .cache_done       (cache_done),
    .mmu_fault        (mmu_fault),
    .mem_req          (mem_req),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_ack          (mem_ack),
    .mem_rdata        (mem_rdata)
  );

  always #4 CPU_CLK = ~CPU_CLK;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected)
      else fail_run($sformatf("mismatch %s %s expected 0x%h actual 0x%h",
                              name, what, expected, actual));
  endtask

  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x         = rng_state;
    x         = x ^ (x << 13);
    x         = x ^ (x >> 17);
    x         = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (mem_image.exists(addr))
      return mem_image[addr];
    return addr ^ fill_key;                      // Untouched words keep the preload
  endfunction

  // ------------------------------
  // Memory model
  // ------------------------------
  initial
  begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      if (!RST && mem_req)
      begin
        rnd       = xorshift_next();
        ack_delay = int'(rnd[1:0]) + 1;          // 1 to 4 cycles
        repeat (ack_delay - 1)
        begin
          @(posedge CPU_CLK);
          #1;
        end
        mem_accesses = mem_accesses + 1;
        last_addr    = mem_addr;
        last_we      = mem_we;
        last_wdata   = mem_wdata;
        if (mem_we)
        begin
          mem_image[mem_addr] = mem_wdata;
          mem_rdata           = '0;
        end
        else
          mem_rdata = model_read(mem_addr);
        mem_ack = 1'b1;
        @(posedge CPU_CLK);                      // Handshake edge
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  // One request from the current data-file line
  task automatic run_request();
    int          cycles;
    int          base_count;
    logic [31:0] exp_paddr;
    assert (!cache_busy)
      else fail_run("cache_busy was high when a new request was due");
    base_count       = mem_accesses;
    cache_enable     = 1'b1;
    cache_op         = snowball_pkg::op_e'(f_op);
    cache_addr       = f_addr;
    cache_wdata      = f_wdata;
    cache_force_miss = f_force_miss;
    cache_inhibit    = f_inhibit;
    vmem_act         = f_vmem;
    @(posedge CPU_CLK);                          // Acceptance edge
    #1;
    cache_enable = 1'b0;
    assert (cache_busy)
      else fail_run("cache_busy did not rise after the request was accepted");
    cycles = 0;
    while (!cache_done)
    begin
      @(posedge CPU_CLK);
      #1;
      cycles = cycles + 1;
    end
    assert (!cache_busy)
      else fail_run("cache_busy still high in the cache_done cycle");
    check_value(f_name, "mmu_fault", {31'd0, f_exp_fault}, {31'd0, mmu_fault});
    check_value(f_name, "mem accesses", f_exp_acc, mem_accesses - base_count);
    if ((f_op == snowball_pkg::op_read) && !f_exp_fault)
      check_value(f_name, "cache_rdata", f_exp_data, cache_rdata);
    if (f_op == snowball_pkg::op_tlb_write)
    begin
      check_value(f_name, "latency", 32'd1, cycles);
      tlb_page[f_addr[15:8]] = f_wdata[15:0];
    end
    else if (f_exp_acc == 0)
      check_value(f_name, "latency", 32'd2, cycles);
    if (f_exp_acc == 1)
    begin
      exp_paddr = f_vmem ? {tlb_page[f_addr[15:8]], f_addr[15:0]} : f_addr;
      check_value(f_name, "mem_addr", exp_paddr, last_addr);
      check_value(f_name, "mem_we", {31'd0, f_op == snowball_pkg::op_write}, {31'd0, last_we});
      if (f_op == snowball_pkg::op_write)
        check_value(f_name, "mem_wdata", f_wdata, last_wdata);
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin : stimulus
    int fd;
    int n;
    int c;
    int line_count;
    RST              = 1'b1;
    cache_enable     = 1'b0;
    cache_op         = snowball_pkg::op_read;
    cache_addr       = '0;
    cache_wdata      = '0;
    cache_force_miss = 1'b0;
    cache_inhibit    = 1'b0;
    vmem_act         = 1'b0;
    fd = $fopen(data_path, "r");
    if (fd == 0)
      fail_run("cannot open the test data file");
    line_count = 0;
    c = $fgetc(fd);
    while (c != -1)
    begin
      if (c == 10)
        line_count = line_count + 1;
      c = $fgetc(fd);
    end
    $fclose(fd);
    watchdog_cycles = line_count * cycles_per_line + reset_cycles;
    repeat (reset_cycles) @(posedge CPU_CLK);
    #1;
    RST = 1'b0;
    assert (!cache_busy && !mem_req && !cache_done && !mmu_fault)
      else fail_run("cache outputs or mem_req not low after reset");
    fd = $fopen(data_path, "r");
    while (!$feof(fd))
    begin
      n = $fscanf(fd, "%s", f_name);
      if (n == 1)
      begin
        if (f_name.getc(0) == "#")               // Column notes
        begin
          c = $fgetc(fd);
          while ((c != 10) && (c != -1))
            c = $fgetc(fd);
        end
        else
        begin
          n = $fscanf(fd, "%d %d %d %d %h %h %h %d %d", f_op, f_force_miss, f_inhibit,
                      f_vmem, f_addr, f_wdata, f_exp_data, f_exp_fault, f_exp_acc);
          if (n != 9)
            fail_run("malformed line in the test data file");
          run_request();
        end
      end
    end
    $fclose(fd);
    $display("All tests passed");
    $finish;
  end

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CPU_CLK);
    fail_run("watchdog expired before all requests completed");
  end

endmodule

// File: tb/snowball_testdata.txt
# name op(0 rd 1 wr 2 tlb) force_miss inhibit vmem addr(hex) wdata(hex) exp_data(hex)
# exp_fault exp_mem_accesses ; unwritten memory reads as address xor 5a5ac3c3
rd_first       0 0 0 0 00001040 00000000 5a5ad383 0 1
rd_hit         0 0 0 0 00001040 00000000 5a5ad383 0 0
rd_zero        0 0 0 0 00000000 00000000 5a5ac3c3 0 1
rd_zero_hit    0 0 0 0 00000000 00000000 5a5ac3c3 0 0
wr_first       1 0 0 0 00002084 cafe0001 00000000 0 1
rd_after_wr    0 0 0 0 00002084 00000000 cafe0001 0 0
wr_alias       1 0 0 0 00011040 12345678 00000000 0 1
rd_alias       0 0 0 0 00011040 00000000 12345678 0 0
rd_evicted     0 0 0 0 00001040 00000000 5a5ad383 0 1
tlb_load       2 0 0 0 00000300 abcd0012 00000000 0 0
vrd_first      0 0 0 1 abcd0310 00000000 5a48c0d3 0 1
vrd_hit        0 0 0 1 abcd0310 00000000 5a48c0d3 0 0
vrd_bad_tag    0 0 0 1 11110320 00000000 00000000 1 0
vrd_no_entry   0 0 0 1 abcd0510 00000000 00000000 1 0
vwr_page       1 0 0 1 abcd0324 0badf00d 00000000 0 1
rd_vwr_phys    0 0 0 0 00120324 00000000 0badf00d 0 0
fm_cached      0 1 0 0 00002084 00000000 cafe0001 0 1
inh_cached     0 0 1 0 00002084 00000000 cafe0001 0 1
inh_first      0 0 1 0 00003008 00000000 5a5af3cb 0 1
rd_after_inh   0 0 0 0 00003008 00000000 5a5af3cb 0 1
rd_inh_filled  0 0 0 0 00003008 00000000 5a5af3cb 0 0
tlb_reload     2 0 0 0 00000300 11110034 00000000 0 0
vrd_reload     0 0 0 1 11110320 00000000 5a6ec0e3 0 1
vrd_stale_tag  0 0 0 1 abcd0310 00000000 00000000 1 0
wr_fm          1 1 0 0 00002084 cafe0002 00000000 0 1
rd_wr_fm       0 0 0 0 00002084 00000000 cafe0002 0 0

// File: vlog.f
design/snowball_pkg.sv
design/mapped_store.sv
design/cache_ctrl.sv
design/mem_port.sv
design/snowball_cache.sv
tb/tb_snowball_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_snowball_cache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
